// File: src/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

	localparam int WORD_W = 32;
	localparam int BYTE_OFF_W = 2;

	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 8;
	localparam int WORDS_PER_LINE = 4;
	localparam int INDEX_W = 3;
	localparam int OFFSET_W = 2;
	localparam int TAG_W = WORD_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

	// galois feedback for x^8 + x^6 + x^5 + x^4 + 1
	localparam logic [7:0] LFSR_TAPS = 8'hb8;
	localparam logic [7:0] LFSR_SEED = 8'h5a;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
		logic [BYTE_OFF_W-1:0] byte_off;
	} addr_fields_t;

	typedef union packed {
		logic [WORD_W-1:0] raw;
		addr_fields_t f;
	} fetch_addr_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_sel_t;

endpackage

`default_nettype wire

// File: src/fetch_bus_pkg.sv
`default_nettype none

package fetch_bus_pkg;

	// stage 1 inputs from the cpu side
	typedef struct packed {
		logic read;
		cache_cfg_pkg::fetch_addr_t address;
		logic flush_1;
		logic flush_2;
	} fetch_req_t;

	typedef struct packed {
		logic stall;
		logic valid;
		logic [cache_cfg_pkg::WORD_W-1:0] rddata;
	} fetch_resp_t;

	// read half of the axi bus only
	typedef struct packed {
		logic arvalid;
		logic [cache_cfg_pkg::WORD_W-1:0] araddr;
		logic rready;
	} axi_rd_req_t;

	typedef struct packed {
		logic arready;
		logic rvalid;
		logic rlast;
		logic [cache_cfg_pkg::WORD_W-1:0] rdata;
	} axi_rd_resp_t;

endpackage

`default_nettype wire

// File: src/way_ram.sv
`timescale 1ns/1ns
`default_nettype none

module way_ram #(
	parameter int DEPTH = cache_cfg_pkg::NUM_SETS,
	parameter type entry_t = cache_cfg_pkg::tag_entry_t
) (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [cache_cfg_pkg::INDEX_W-1:0] addr,
	input entry_t din,
	output entry_t dout
);

	entry_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			dout <= '0;
		end else begin
			if (we) begin
				mem[addr] <= din;
			end
			// read-first so a write shows up one access later
			dout <= mem[addr];
		end
	end

	a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(addr));

endmodule

`default_nettype wire

// File: src/victim_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module victim_lfsr (
	input logic clk,
	input logic rst,
	input logic step,
	output cache_cfg_pkg::way_sel_t way
);

	logic [7:0] lfsr;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= cache_cfg_pkg::LFSR_SEED;
		end else if (step) begin
			lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? cache_cfg_pkg::LFSR_TAPS : 8'h00);
		end
	end

	assign way = lfsr[0];

endmodule

`default_nettype wire

// File: src/line_refill.sv
`timescale 1ns/1ns
`default_nettype none

module line_refill (
	input logic clk,
	input logic rst,
	input cache_cfg_pkg::fetch_addr_t stage2_addr,
	input logic miss,
	input logic flush_2,
	output fetch_bus_pkg::axi_rd_req_t axi_req,
	input fetch_bus_pkg::axi_rd_resp_t axi_resp,
	input cache_cfg_pkg::way_sel_t victim,
	output logic [cache_cfg_pkg::NUM_WAYS-1:0] tag_we,
	output logic [cache_cfg_pkg::NUM_WAYS-1:0] data_we,
	output cache_cfg_pkg::tag_entry_t tag_wr,
	output cache_cfg_pkg::line_t line_wr,
	output logic ram_index_sel,
	output logic refill_busy,
	output logic fill_step
);

	typedef enum logic [2:0] {
		s_idle,
		s_wait_ready,
		s_receiving,
		s_finish,
		s_flush_wait_ready,
		s_flush_receiving
	} state_t;

	state_t state, state_d;
	logic [cache_cfg_pkg::OFFSET_W-1:0] beat_cnt;
	cache_cfg_pkg::line_t line_buf;
	cache_cfg_pkg::fetch_addr_t refill_addr;
	cache_cfg_pkg::fetch_addr_t line_addr;
	logic beat;
	logic last_beat;

	always_comb begin
		state_d = state;
		unique case (state)
			s_idle: begin
				if (miss && !flush_2) begin
					state_d = s_wait_ready;
				end
			end
			s_wait_ready: begin
				if (axi_resp.arready) begin
					state_d = flush_2 ? s_flush_receiving : s_receiving;
				end else if (flush_2) begin
					state_d = s_flush_wait_ready;
				end
			end
			s_flush_wait_ready: begin
				if (axi_resp.arready) begin
					state_d = s_flush_receiving;
				end
			end
			s_receiving: begin
				if (last_beat) begin
					state_d = s_finish;
				end else if (flush_2) begin
					state_d = s_flush_receiving;
				end
			end
			s_flush_receiving: begin
				if (last_beat) begin
					state_d = s_finish;
				end
			end
			s_finish: state_d = s_idle;
			default: state_d = s_idle;
		endcase
	end

	// burst start is the line base of the missed address
	always_comb begin
		line_addr = refill_addr;
		line_addr.f.offset = '0;
		line_addr.f.byte_off = '0;
	end

	assign axi_req.arvalid = (state == s_wait_ready) || (state == s_flush_wait_ready);
	assign axi_req.araddr = line_addr.raw;
	assign axi_req.rready = (state == s_receiving) || (state == s_flush_receiving);

	assign beat = axi_req.rready && axi_resp.rvalid;
	assign last_beat = beat && axi_resp.rlast;

	// a late flush_2 still drops the line
	assign fill_step = (state == s_receiving) && last_beat && !flush_2;

	for (genvar w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin : g_we
		assign tag_we[w] = fill_step && (victim == cache_cfg_pkg::way_sel_t'(w));
		assign data_we[w] = fill_step && (victim == cache_cfg_pkg::way_sel_t'(w));
	end

	assign tag_wr.valid = 1'b1;
	assign tag_wr.tag = refill_addr.f.tag;

	always_comb begin
		line_wr = line_buf;
		line_wr[beat_cnt] = axi_resp.rdata;
	end

	// write cycle and re-read cycle both address the stage-2 set
	assign ram_index_sel = (state_d == s_finish) || (state == s_finish);
	assign refill_busy = (state != s_idle) || (state_d != s_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			beat_cnt <= '0;
		end else begin
			state <= state_d;
			if (axi_req.arvalid && axi_resp.arready) begin
				beat_cnt <= '0;
			end else if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat) begin
			line_buf[beat_cnt] <= axi_resp.rdata;
		end
		if (state == s_idle && miss) begin
			refill_addr <= stage2_addr;
		end
	end

	a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
		axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid && $stable(axi_req.araddr));

	a_rlast_fourth: assert property (@(posedge clk) disable iff (rst)
		beat |-> axi_resp.rlast == (int'(beat_cnt) == cache_cfg_pkg::WORDS_PER_LINE - 1));

endmodule

`default_nettype wire

// File: src/fetch_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_lookup (
	input logic clk,
	input logic rst,
	input fetch_bus_pkg::fetch_req_t req,
	output fetch_bus_pkg::fetch_resp_t resp,
	input cache_cfg_pkg::tag_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] tag_rd,
	input cache_cfg_pkg::line_t [cache_cfg_pkg::NUM_WAYS-1:0] line_rd,
	input logic refill_busy,
	output cache_cfg_pkg::fetch_addr_t stage2_addr,
	output logic miss
);

	logic pipe_read;
	cache_cfg_pkg::fetch_addr_t pipe_addr;
	logic [cache_cfg_pkg::NUM_WAYS-1:0] hit;
	logic [cache_cfg_pkg::WORD_W-1:0] hit_word;

	// stage-2 register
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_read <= 1'b0;
		end else if (!resp.stall) begin
			pipe_read <= req.read && !req.flush_1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resp.stall) begin
			pipe_addr <= req.address;
		end
	end

	for (genvar w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin : g_hit
		assign hit[w] = tag_rd[w].valid && (tag_rd[w].tag == pipe_addr.f.tag);
	end

	always_comb begin
		hit_word = '0;
		for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
			hit_word |= {cache_cfg_pkg::WORD_W{hit[w]}} & line_rd[w][pipe_addr.f.offset];
		end
	end

	assign miss = pipe_read && !(|hit);
	assign stage2_addr = pipe_addr;

	// busy already includes the miss cycle via the refill next state
	always_comb begin
		resp.stall = pipe_read && refill_busy && !req.flush_2;
		resp.valid = pipe_read && !refill_busy && !req.flush_2;
		resp.rddata = hit_word;
	end

	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		pipe_read && !refill_busy |-> $onehot0(hit));

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
	input logic clk,
	input logic rst,
	input fetch_bus_pkg::fetch_req_t fetch_req,
	output fetch_bus_pkg::fetch_resp_t fetch_resp,
	output fetch_bus_pkg::axi_rd_req_t axi_req,
	input fetch_bus_pkg::axi_rd_resp_t axi_resp
);

	cache_cfg_pkg::tag_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] tag_rd;
	cache_cfg_pkg::line_t [cache_cfg_pkg::NUM_WAYS-1:0] line_rd;
	cache_cfg_pkg::tag_entry_t tag_wr;
	cache_cfg_pkg::line_t line_wr;
	logic [cache_cfg_pkg::NUM_WAYS-1:0] tag_we;
	logic [cache_cfg_pkg::NUM_WAYS-1:0] data_we;
	cache_cfg_pkg::fetch_addr_t stage2_addr;
	cache_cfg_pkg::way_sel_t victim;
	logic [cache_cfg_pkg::INDEX_W-1:0] ram_index;
	logic miss;
	logic refill_busy;
	logic ram_index_sel;
	logic fill_step;

	// stage-2 set only while the stage-2 register is held
	assign ram_index = (ram_index_sel && fetch_resp.stall) ? stage2_addr.f.index
		: fetch_req.address.f.index;

	fetch_lookup lookup_i (
		.clk(clk),
		.rst(rst),
		.req(fetch_req),
		.resp(fetch_resp),
		.tag_rd(tag_rd),
		.line_rd(line_rd),
		.refill_busy(refill_busy),
		.stage2_addr(stage2_addr),
		.miss(miss)
	);

	line_refill refill_i (
		.clk(clk),
		.rst(rst),
		.stage2_addr(stage2_addr),
		.miss(miss),
		.flush_2(fetch_req.flush_2),
		.axi_req(axi_req),
		.axi_resp(axi_resp),
		.victim(victim),
		.tag_we(tag_we),
		.data_we(data_we),
		.tag_wr(tag_wr),
		.line_wr(line_wr),
		.ram_index_sel(ram_index_sel),
		.refill_busy(refill_busy),
		.fill_step(fill_step)
	);

	victim_lfsr lfsr_i (
		.clk(clk),
		.rst(rst),
		.step(fill_step),
		.way(victim)
	);

	for (genvar w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin : g_way
		way_ram #(
			.DEPTH(cache_cfg_pkg::NUM_SETS),
			.entry_t(cache_cfg_pkg::tag_entry_t)
		) tag_ram_i (
			.clk(clk),
			.rst(rst),
			.we(tag_we[w]),
			.addr(ram_index),
			.din(tag_wr),
			.dout(tag_rd[w])
		);

		way_ram #(
			.DEPTH(cache_cfg_pkg::NUM_SETS),
			.entry_t(cache_cfg_pkg::line_t)
		) line_ram_i (
			.clk(clk),
			.rst(rst),
			.we(data_we[w]),
			.addr(ram_index),
			.din(line_wr),
			.dout(line_rd[w])
		);
	end

endmodule

`default_nettype wire

// File: bench/axi_rom_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_rom_model (
	input logic clk,
	input logic rst,
	input logic [1:0] ar_delay,
	input fetch_bus_pkg::axi_rd_req_t axi_req,
	output fetch_bus_pkg::axi_rd_resp_t axi_resp
);

	typedef enum logic [1:0] {
		p_idle,
		p_addr,
		p_data
	} phase_t;

	phase_t phase;
	logic [1:0] wait_cnt;
	logic [cache_cfg_pkg::WORD_W-1:0] burst_addr;
	int beat_idx;

	function automatic logic [cache_cfg_pkg::WORD_W-1:0] rom_data(
		input logic [cache_cfg_pkg::WORD_W-1:0] addr
	);
		return ~{addr[cache_cfg_pkg::WORD_W-1:2], 2'b00};
	endfunction

	// decide on the edge and drive 5 ns later
	initial begin
		phase = p_idle;
		wait_cnt = '0;
		burst_addr = '0;
		beat_idx = 0;
		axi_resp = '0;
		forever begin
			@(posedge clk);
			if (rst) begin
				phase = p_idle;
				beat_idx = 0;
			end else begin
				case (phase)
					p_idle: begin
						if (axi_req.arvalid) begin
							wait_cnt = ar_delay;
							phase = p_addr;
						end
					end
					p_addr: begin
						if (axi_resp.arready) begin
							burst_addr = axi_req.araddr;
							beat_idx = 0;
							phase = p_data;
						end else begin
							wait_cnt = wait_cnt - 1'b1;
						end
					end
					p_data: begin
						if (axi_req.rready) begin
							beat_idx++;
							if (beat_idx == cache_cfg_pkg::WORDS_PER_LINE) begin
								phase = p_idle;
							end
						end
					end
					default: phase = p_idle;
				endcase
			end
			#5;
			axi_resp.arready = (phase == p_addr) && (wait_cnt == 2'd0);
			axi_resp.rvalid = (phase == p_data);
			axi_resp.rlast = (phase == p_data)
				&& (beat_idx == cache_cfg_pkg::WORDS_PER_LINE - 1);
			axi_resp.rdata = (phase == p_data) ? rom_data(burst_addr + 32'(4 * beat_idx)) : '0;
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache;

	localparam int RESET_CYCLES = 8;
	// request, miss, 3 wait cycles, handshake, 4 beats, finish, result
	localparam int MISS_MAX = 12;
	localparam int FETCH_MAX = MISS_MAX + 4;
	localparam int NUM_FETCHES = 20;
	localparam int OTHER_CYCLES = 8 + 2 * MISS_MAX + FETCH_MAX;
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_FETCHES * FETCH_MAX + OTHER_CYCLES + 64;

	localparam int INDEX_LSB = cache_cfg_pkg::OFFSET_W + cache_cfg_pkg::BYTE_OFF_W;
	localparam int TAG_LSB = INDEX_LSB + cache_cfg_pkg::INDEX_W;

	localparam logic [31:0] COLD_ADDR = 32'h0000_1038;

	logic clk;
	logic rst;
	logic [1:0] ar_delay;
	fetch_bus_pkg::fetch_req_t fetch_req;
	fetch_bus_pkg::fetch_resp_t fetch_resp;
	fetch_bus_pkg::axi_rd_req_t axi_req;
	fetch_bus_pkg::axi_rd_resp_t axi_resp;

	logic [7:0] lfsr_state = 8'd8;
	logic [31:0] ar_log [$];
	int valid_cnt = 0;
	int stall_cnt = 0;
	int last_cnt = 0;
	int cycle_cnt = 0;
	int checks = 0;
	int errors = 0;

	icache_top icache_top_i (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_resp(fetch_resp),
		.axi_req(axi_req),
		.axi_resp(axi_resp)
	);

	axi_rom_model rom_i (
		.clk(clk),
		.rst(rst),
		.ar_delay(ar_delay),
		.axi_req(axi_req),
		.axi_resp(axi_resp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	// bus and response activity sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (axi_req.arvalid && axi_resp.arready) begin
				ar_log.push_back(axi_req.araddr);
			end
			if (axi_req.rready && axi_resp.rvalid && axi_resp.rlast) begin
				last_cnt++;
			end
			if (fetch_resp.valid) begin
				valid_cnt++;
			end
			if (fetch_resp.stall) begin
				stall_cnt++;
			end
			if (fetch_resp.valid && fetch_resp.stall) begin
				errors++;
				$display("valid and stall are high in the same cycle");
			end
			if (fetch_resp.valid && fetch_req.flush_2) begin
				errors++;
				$display("valid is high in a cycle with flush_2");
			end
		end
	end

	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {1'b0, s[7:1]} ^ (s[0] ? 8'h8e : 8'h00);
	endfunction

	function automatic logic random_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// memory rule is the complement of the word-aligned byte address
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return ~(addr & ~32'h3);
	endfunction

	function automatic logic [31:0] line_base(input logic [31:0] addr);
		return addr & ~32'(4 * cache_cfg_pkg::WORDS_PER_LINE - 1);
	endfunction

	function automatic logic [31:0] compose_addr(input int tag, input int index, input int offset);
		return 32'((tag << TAG_LSB) | (index << INDEX_LSB) | (offset << 2));
	endfunction

	task automatic check_word(
		input string name,
		input logic [cache_cfg_pkg::WORD_W-1:0] expected,
		input logic [cache_cfg_pkg::WORD_W-1:0] actual
	);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_axi_addr(
		input string name,
		input logic [cache_cfg_pkg::WORD_W-1:0] expected,
		input logic [cache_cfg_pkg::WORD_W-1:0] actual
	);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected araddr %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// drive one request and return 5 ns after the edge that takes it
	task automatic issue_request(input logic [31:0] addr, input logic flush_1);
		fetch_req.read = 1'b1;
		fetch_req.address.raw = addr;
		fetch_req.flush_1 = flush_1;
		fetch_req.flush_2 = 1'b0;
		@(negedge clk);
		while (fetch_resp.stall) begin
			@(negedge clk);
		end
		@(posedge clk);
		#5;
		fetch_req = '0;
	endtask

	task automatic fetch_word(
		input string name,
		input logic [31:0] addr,
		output int bursts,
		output int latency
	);
		int first_burst;
		int i;
		logic done;
		first_burst = ar_log.size();
		issue_request(addr, 1'b0);
		done = 1'b0;
		latency = 0;
		while (!done) begin
			@(negedge clk);
			latency++;
			if (fetch_resp.valid) begin
				done = 1'b1;
				check_word(name, expected_word(addr), fetch_resp.rddata);
			end else if (!fetch_resp.stall) begin
				done = 1'b1;
				errors++;
				$display("%s: fetch of %h ended with neither valid nor stall", name, addr);
			end
		end
		@(posedge clk);
		#5;
		bursts = ar_log.size() - first_burst;
		for (i = first_burst; i < ar_log.size(); i++) begin
			check_axi_addr(name, line_base(addr), ar_log[i]);
		end
	endtask

	task automatic stream_line_hits(input string name, input logic [31:0] base, input int count);
		logic [31:0] addr;
		logic [31:0] prev;
		int i;
		prev = '0;
		for (i = 0; i <= count; i++) begin
			addr = base + 32'(4 * (i % cache_cfg_pkg::WORDS_PER_LINE));
			if (i < count) begin
				fetch_req.read = 1'b1;
				fetch_req.address.raw = addr;
			end else begin
				fetch_req = '0;
			end
			@(negedge clk);
			if (fetch_resp.stall) begin
				errors++;
				$display("%s: stall during a stream of hits", name);
			end
			if (i > 0) begin
				if (!fetch_resp.valid) begin
					errors++;
					$display("%s: no valid for the back-to-back hit at %h", name, prev);
				end else begin
					check_word(name, expected_word(prev), fetch_resp.rddata);
				end
			end
			prev = addr;
			@(posedge clk);
			#5;
		end
	endtask

	task automatic cold_miss_fetch();
		int bursts;
		int latency;
		fetch_word("cold miss", COLD_ADDR, bursts, latency);
		compare_count("cold miss bursts", 1, bursts);
	endtask

	task automatic line_hits();
		logic [31:0] addr;
		int first_burst;
		int bursts;
		int latency;
		int i;
		first_burst = ar_log.size();
		// the other three words of the cold-miss line
		for (i = 0; i < cache_cfg_pkg::WORDS_PER_LINE; i++) begin
			addr = line_base(COLD_ADDR) + 32'(4 * i);
			if (addr != COLD_ADDR) begin
				fetch_word("hit", addr, bursts, latency);
				compare_count("hit latency", 1, latency);
			end
		end
		stream_line_hits("hit stream", line_base(COLD_ADDR), 6);
		compare_count("hit bursts", 0, ar_log.size() - first_burst);
	endtask

	task automatic eviction_refetch();
		logic [31:0] addr;
		int refetch_bursts;
		int bursts;
		int latency;
		int r;
		int i;
		refetch_bursts = 0;
		for (r = 0; r < 2; r++) begin
			for (i = 0; i < 3; i++) begin
				addr = compose_addr(16 * (i + 1), 5, i);
				fetch_word("eviction", addr, bursts, latency);
				if (r == 0) begin
					compare_count("eviction first round bursts", 1, bursts);
				end else begin
					refetch_bursts += bursts;
				end
			end
		end
		// three lines cannot all stay in a two-way set
		if (refetch_bursts == 0) begin
			errors++;
			$display("eviction: refetch of three lines in one set caused no burst");
		end
	endtask

	task automatic flush_in_stage1();
		int first_burst;
		int first_valid;
		int first_stall;
		first_burst = ar_log.size();
		first_valid = valid_cnt;
		first_stall = stall_cnt;
		issue_request(32'h0000_2004, 1'b1);
		issue_request(32'h0000_1034, 1'b1);
		repeat (MISS_MAX) @(posedge clk);
		#5;
		compare_count("flush_1 valids", 0, valid_cnt - first_valid);
		compare_count("flush_1 stalls", 0, stall_cnt - first_stall);
		compare_count("flush_1 bursts", 0, ar_log.size() - first_burst);
	endtask

	task automatic flush_during_refill();
		logic [31:0] addr;
		int first_burst;
		int first_valid;
		int first_last;
		int bursts;
		int latency;
		addr = 32'h0000_3044;
		first_burst = ar_log.size();
		first_valid = valid_cnt;
		first_last = last_cnt;
		issue_request(addr, 1'b0);
		// cancel once the burst is under way
		@(negedge clk);
		while (!(axi_req.rready && axi_resp.rvalid)) begin
			@(negedge clk);
		end
		@(posedge clk);
		#5;
		fetch_req.flush_2 = 1'b1;
		@(posedge clk);
		#5;
		fetch_req.flush_2 = 1'b0;
		while (last_cnt == first_last) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		#5;
		compare_count("flush_2 bursts", 1, ar_log.size() - first_burst);
		compare_count("flush_2 valids", 0, valid_cnt - first_valid);
		if (ar_log.size() > first_burst) begin
			check_axi_addr("flush_2 burst", line_base(addr), ar_log[first_burst]);
		end
		fetch_word("flush_2 refetch", addr, bursts, latency);
		compare_count("flush_2 refetch bursts", 1, bursts);
	endtask

	task automatic memory_backpressure();
		logic [31:0] addr;
		int bursts;
		int latency;
		int i;
		for (i = 0; i < 8; i++) begin
			ar_delay[1] = random_bit();
			ar_delay[0] = random_bit();
			addr = compose_addr(32'h100 + i, i, i % cache_cfg_pkg::WORDS_PER_LINE);
			fetch_word("backpressure", addr, bursts, latency);
			compare_count("backpressure bursts", 1, bursts);
		end
		ar_delay = '0;
	endtask

	initial begin
		rst = 1'b1;
		fetch_req = '0;
		ar_delay = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst = 1'b0;
		@(negedge clk);
		if (fetch_resp.stall || fetch_resp.valid || axi_req.arvalid || axi_req.rready) begin
			errors++;
			$display("stall, valid, arvalid or rready is high after reset");
		end
		@(posedge clk);
		#5;
		cold_miss_fetch();
		line_hits();
		eviction_refetch();
		flush_in_stage1();
		flush_during_refill();
		memory_backpressure();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
src/cache_cfg_pkg.sv
src/fetch_bus_pkg.sv
src/way_ram.sv
src/victim_lfsr.sv
src/line_refill.sv
src/fetch_lookup.sv
src/icache_top.sv
bench/axi_rom_model.sv
bench/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - src/cache_cfg_pkg.sv
  - src/fetch_bus_pkg.sv
  - src/way_ram.sv
  - src/victim_lfsr.sv
  - src/line_refill.sv
  - src/fetch_lookup.sv
  - src/icache_top.sv
  - target: test
    files:
      - bench/axi_rom_model.sv
      - bench/tb_icache.sv
